//--- Bender.yml
package:
  name: cong_man

sources:
  - include_dirs:
      - design
    files:
      - design/cong_man_pkg.sv
      - design/drop_threshold_table.sv
      - design/queue_occupancy_tracker.sv
      - design/drop_counter_bank.sv
      - design/cong_pipeline.sv
      - design/cong_man_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - bench/cong_man_clock.sv
      - bench/cong_man_checker.sv
      - bench/cong_man_tb.sv

//--- bench/cong_man_checker.sv
// Protocol assertions bound to the congestion manager top level

module cong_man_checker (
    input logic counter_access,
    input logic reset,
    input logic pkt_out_valid,
    input logic pkt_out_last,
    input logic cfg_rd,
    input logic cfg_rvalid,
    input logic cnt_req,
    input logic cnt_ready,
    input logic cnt_rvalid
);
    timeunit 1ns;
    timeprecision 1ps;

    // Outputs stay quiet through a reset cycle
    assert property (@(posedge counter_access) reset ##1 reset |->
                     !pkt_out_valid && !pkt_out_last && !cfg_rvalid && !cnt_rvalid && !cnt_ready)
        else $error("Output active while reset is applied");

    // Counter access response one cycle after acceptance, and only then
    assert property (@(posedge counter_access) disable iff (reset)
                     cnt_req && cnt_ready |=> cnt_rvalid)
        else $error("cnt_rvalid missing after an accepted request");
    assert property (@(posedge counter_access) disable iff (reset)
                     cnt_rvalid |-> $past(cnt_req && cnt_ready))
        else $error("cnt_rvalid without an accepted request");

    // Config read data one cycle after the strobe
    assert property (@(posedge counter_access) disable iff (reset) cfg_rd |=> cfg_rvalid)
        else $error("cfg_rvalid missing after cfg_rd");
    assert property (@(posedge counter_access) disable iff (reset) cfg_rvalid |-> $past(cfg_rd))
        else $error("cfg_rvalid without cfg_rd");

endmodule

bind cong_man_top cong_man_checker cong_man_checker_i (
    .counter_access (counter_access),
    .reset          (reset),
    .pkt_out_valid  (pkt_out_valid),
    .pkt_out_last   (pkt_out_last),
    .cfg_rd         (cfg_rd),
    .cfg_rvalid     (cfg_rvalid),
    .cnt_req        (cnt_req),
    .cnt_ready      (cnt_ready),
    .cnt_rvalid     (cnt_rvalid)
);

//--- bench/cong_man_clock.sv
// Clock and reset for the congestion manager testbench

module cong_man_clock (
    output logic counter_access,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    // 100 ns period
    initial begin
        counter_access = 1'b0;
        forever #50 counter_access = ~counter_access;
    end

    // Held for three rising edges
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge counter_access);
        reset <= 1'b0;
    end

endmodule

//--- bench/cong_man_tb.sv
// Congestion manager testbench
// Runs the testdata command list and checks every DUT response
`include "cong_man_settings.svh"

module cong_man_tb import cong_man_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam string TESTDATA_PATH   = "bench/cong_man_testdata.txt";
    localparam int    CYCLES_PER_LINE = 40;
    localparam int    SWEEP_CYCLES    = `CM_NUM_QUEUES * `CM_NUM_DROP_TYPES;

    // Expected output word, recorded as the word enters the DUT
    typedef struct packed {
        logic                      valid;
        logic                      last;
        logic [`CM_DATA_WIDTH-1:0] data;
        out_meta_t                 meta;
    } expected_word_t;

    logic                      counter_access;
    logic                      reset;
    pkt_word_t                 pkt_in;
    logic                      deq_valid;
    queue_id_t                 deq_queue;
    byte_len_t                 deq_bytes;
    logic                      cfg_wr;
    logic                      cfg_rd;
    queue_id_t                 cfg_queue;
    occupancy_t                cfg_wdata;
    logic                      cfg_rvalid;
    occupancy_t                cfg_rdata;
    logic                      cnt_req;
    cnt_op_t                   cnt_op;
    queue_id_t                 cnt_queue;
    drop_type_t                cnt_type;
    logic                      cnt_ready;
    logic                      cnt_rvalid;
    counter_t                  cnt_rdata;
    logic                      pkt_out_valid;
    logic                      pkt_out_last;
    logic [`CM_DATA_WIDTH-1:0] pkt_out_data;
    out_meta_t                 pkt_out_meta;

    // Fate and metadata of the packet now on pkt_in
    logic           cur_drop;
    out_meta_t      cur_meta;
    expected_word_t in_flight [$];
    string          lines [$];
    int             drop_count [`CM_NUM_QUEUES][`CM_NUM_DROP_TYPES] = '{default: 0};
    int             watchdog_cycles = 0;

    cong_man_clock cong_man_clock_i (
        .counter_access (counter_access),
        .reset          (reset)
    );

    cong_man_top cong_man_top_i (.*);

    ////////////////////////////////////////////////////////////////////////////
    // Checking

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            stop_run($sformatf("** Error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    // Priorities 7, 6 and 5 own queues 3, 2 and 1, the rest share queue 0
    function automatic queue_id_t expected_queue(input egr_port_t port, input prio_t prio);
        logic [1:0] class_idx;
        class_idx = (prio >= 3'd5) ? 2'(prio - 3'd4) : 2'd0;
        return {port, class_idx};
    endfunction

    // Each word leaves the DUT three cycles after it went in
    always @(negedge counter_access) begin
        expected_word_t entry;
        if (reset === 1'b0) begin
            entry.valid = pkt_in.valid && !cur_drop;
            entry.last  = pkt_in.valid && pkt_in.last && !cur_drop;
            entry.data  = pkt_in.data;
            entry.meta  = cur_meta;
            in_flight.push_back(entry);
            if (in_flight.size() > 3) begin
                entry = in_flight.pop_front();
                check_value("pkt_out_valid", pkt_out_valid, entry.valid);
                check_value("pkt_out_last", pkt_out_last, entry.last);
                if (entry.valid) begin
                    check_value("pkt_out_data", pkt_out_data, entry.data);
                    check_value("pkt_out_meta", pkt_out_meta, entry.meta);
                end
            end
        end
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge counter_access);
        stop_run("Run timed out before all testdata lines were done");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Command tasks

    // Idle the packet input and let the pipeline empty
    task automatic drain();
        @(posedge counter_access);
        pkt_in.valid <= 1'b0;
        pkt_in.last  <= 1'b0;
        repeat (4) @(posedge counter_access);
    endtask

    task automatic write_threshold(input queue_id_t queue, input occupancy_t value);
        @(posedge counter_access);
        cfg_wr    <= 1'b1;
        cfg_queue <= queue;
        cfg_wdata <= value;
        @(posedge counter_access);
        cfg_wr <= 1'b0;
    endtask

    task automatic read_threshold(input queue_id_t queue, input occupancy_t expected);
        @(posedge counter_access);
        cfg_rd    <= 1'b1;
        cfg_queue <= queue;
        @(posedge counter_access);
        cfg_rd <= 1'b0;
        @(negedge counter_access);
        check_value("cfg_rvalid", cfg_rvalid, 1'b1);
        check_value("cfg_rdata", cfg_rdata, expected);
    endtask

    task automatic dequeue(input queue_id_t queue, input byte_len_t bytes);
        @(posedge counter_access);
        deq_valid <= 1'b1;
        deq_queue <= queue;
        deq_bytes <= bytes;
        @(posedge counter_access);
        deq_valid <= 1'b0;
    endtask

    // drop is 0 for pass, 1 for policer, 2 for queue full
    task automatic send_packet(input egr_port_t port, input prio_t prio, input byte_len_t len,
                               input logic mark, input int words, input int drop);
        queue_id_t queue;
        queue = expected_queue(port, prio);
        if (drop != 0) begin
            drop_count[queue][drop - 1]++;
        end
        for (int w = 0; w < words; w++) begin
            @(posedge counter_access);
            pkt_in.valid <= 1'b1;
            pkt_in.last  <= (w == words - 1);
            pkt_in.data  <= {$urandom, $urandom};
            pkt_in.meta  <= '{egress_port: port, prio: prio, byte_len: len, policer_mark: mark};
            cur_drop     <= (drop != 0);
            cur_meta     <= '{queue_id: queue, byte_len: len};
        end
    endtask

    task automatic access_counter(input cnt_op_t op, input queue_id_t queue,
                                  input drop_type_t dtype);
        counter_t expected;
        int       low_cycles;
        expected = (op == CLEAR_ALL) ? '0 : counter_t'(drop_count[queue][dtype]);
        @(posedge counter_access);
        cnt_req   <= 1'b1;
        cnt_op    <= op;
        cnt_queue <= queue;
        cnt_type  <= dtype;
        @(negedge counter_access);
        while (!cnt_ready) @(negedge counter_access);
        @(posedge counter_access);
        cnt_req <= 1'b0;
        @(negedge counter_access);
        check_value("cnt_rvalid", cnt_rvalid, 1'b1);
        check_value("cnt_rdata", cnt_rdata, expected);
        if (op == READ_AND_CLEAR) begin
            drop_count[queue][dtype] = 0;
        end
        if (op == CLEAR_ALL) begin
            foreach (drop_count[q, t]) drop_count[q][t] = 0;
            low_cycles = 0;
            while (!cnt_ready) begin
                low_cycles++;
                @(negedge counter_access);
            end
            check_value("cnt_ready low cycles", low_cycles, SWEEP_CYCLES);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        int          fd;
        int          low_cycles;
        string       line;
        byte         cmd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
        logic [31:0] f;

        pkt_in    = '0;
        deq_valid = 1'b0;
        deq_queue = '0;
        deq_bytes = '0;
        cfg_wr    = 1'b0;
        cfg_rd    = 1'b0;
        cfg_queue = '0;
        cfg_wdata = '0;
        cnt_req   = 1'b0;
        cnt_op    = READ;
        cnt_queue = '0;
        cnt_type  = POLICER_DROP;
        cur_drop  = 1'b0;
        cur_meta  = '0;
        void'($urandom(32'h8ff9));

        fd = $fopen(TESTDATA_PATH, "r");
        if (fd == 0) begin
            stop_run("Could not open the testdata file");
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
        watchdog_cycles = lines.size() * CYCLES_PER_LINE + 100;

        // Counter sweep right after reset
        @(negedge counter_access);
        while (reset !== 1'b0) @(negedge counter_access);
        low_cycles = 0;
        while (!cnt_ready) begin
            low_cycles++;
            @(negedge counter_access);
        end
        check_value("cnt_ready low cycles", low_cycles, SWEEP_CYCLES);

        foreach (lines[i]) begin
            void'($sscanf(lines[i], "%c %h %h %h %h %h %h", cmd, a, b, c, d, e, f));
            if (cmd != "P") begin
                drain();
            end
            case (cmd)
                "W": write_threshold(queue_id_t'(a), occupancy_t'(b));
                "R": read_threshold(queue_id_t'(a), occupancy_t'(b));
                "D": dequeue(queue_id_t'(a), byte_len_t'(b));
                "P": send_packet(egr_port_t'(a), prio_t'(b), byte_len_t'(c), d[0],
                                 int'(e), int'(f));
                "C": access_counter(cnt_op_t'(a[1:0]), queue_id_t'(b), drop_type_t'(c[0]));
                default: stop_run({"Unknown command in testdata: ", lines[i]});
            endcase
        end

        drain();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- bench/cong_man_testdata.txt
# Fields in hex. W queue threshold, R queue expected, D queue bytes, C op queue type
# P port prio length policer_mark words drop (drop 0 pass, 1 policer, 2 queue full)
R 0 ffff
R f ffff
W 5 0100
R 5 0100
W 0 0040
R 0 0040
P 0 0 040 0 3 0
P 0 2 001 0 1 2
D 0 7ff
P 0 1 040 0 2 0
P 2 7 100 0 2 0
P 3 5 020 1 2 1
P 3 3 020 1 1 1
P 2 4 010 1 1 1
P 3 6 020 1 2 0
P 1 7 020 1 1 0
P 0 0 020 1 1 1
P 1 5 080 0 2 0
P 1 5 080 0 1 0
P 1 5 001 0 1 2
P 1 5 010 1 1 1
P 1 5 001 0 2 2
D 5 0c0
P 1 5 0c0 0 2 0
P 1 5 001 0 1 2
C 0 5 1
C 0 5 0
C 0 0 1
C 0 8 0
C 1 d 0
C 0 d 0
C 0 c 0
C 2 0 0
C 0 5 1
C 0 0 0
P 0 0 020 1 1 1
C 0 0 0

//--- cong_man.f
+incdir+design
design/cong_man_pkg.sv
design/drop_threshold_table.sv
design/queue_occupancy_tracker.sv
design/drop_counter_bank.sv
design/cong_pipeline.sv
design/cong_man_top.sv
bench/cong_man_clock.sv
bench/cong_man_checker.sv
bench/cong_man_tb.sv

//--- design/cong_man_pkg.sv
// Congestion manager types
// Packet word layout, queue numbering and drop counter encodings
`include "cong_man_settings.svh"

package cong_man_pkg;

    typedef logic [2:0]                              prio_t;
    typedef logic [$clog2(`CM_NUM_EGR_PORTS)-1:0]    egr_port_t;
    // Port in the upper bits, queue within the port in the lower bits
    typedef logic [$clog2(`CM_NUM_QUEUES)-1:0]       queue_id_t;
    typedef logic [`CM_BYTE_LEN_WIDTH-1:0]           byte_len_t;
    typedef logic [`CM_OCC_WIDTH-1:0]                occupancy_t;
    typedef logic [`CM_CNT_WIDTH-1:0]                counter_t;

    // Valid on the first word of a packet only
    typedef struct packed {
        egr_port_t egress_port;
        prio_t     prio;
        byte_len_t byte_len;
        logic      policer_mark;
    } pkt_meta_t;

    typedef struct packed {
        logic                      valid;
        logic                      last;
        logic [`CM_DATA_WIDTH-1:0] data;
        pkt_meta_t                 meta;
    } pkt_word_t;

    typedef struct packed {
        queue_id_t queue_id;
        byte_len_t byte_len;
    } out_meta_t;

    typedef enum logic [$clog2(`CM_NUM_DROP_TYPES)-1:0] {
        POLICER_DROP    = 0,
        QUEUE_FULL_DROP = 1
    } drop_type_t;

    typedef enum logic [1:0] {
        READ,
        READ_AND_CLEAR,
        CLEAR_ALL
    } cnt_op_t;

    typedef enum logic {
        INIT,
        ACTIVE
    } counter_state_t;

    typedef struct packed {
        logic       valid;
        queue_id_t  queue_id;
        drop_type_t drop_type;
    } drop_event_t;

    // Priority to queue within the egress port
    function automatic logic [$clog2(`CM_QUEUES_PER_PORT)-1:0] prio_to_queue(input prio_t prio);
        case (prio)
            3'd7:    return 2'd3; // emergency
            3'd6:    return 2'd2; // network control
            3'd5:    return 2'd1; // voice
            default: return 2'd0;
        endcase
    endfunction

endpackage

//--- design/cong_man_settings.svh
// Congestion manager build settings
// Widths and counts shared by the RTL and the testbench

`ifndef CONG_MAN_SETTINGS_SVH
`define CONG_MAN_SETTINGS_SVH

// Packet word width in bits
`define CM_DATA_WIDTH 64

// Egress ports and queues per port
`define CM_NUM_EGR_PORTS 4
`define CM_QUEUES_PER_PORT 4
`define CM_NUM_QUEUES 16

// Packet length field, in bytes
`define CM_BYTE_LEN_WIDTH 11

// Queue occupancy and drop thresholds share this width
`define CM_OCC_WIDTH 16

// Drop counter width
`define CM_CNT_WIDTH 32

// Policer drop and queue-full drop
`define CM_NUM_DROP_TYPES 2

// Priorities from here up bypass the policer
`define CM_POLICER_BYPASS_PRIO 6

`endif

//--- design/cong_man_top.sv
// Congestion manager top level
// Packet pipeline with threshold table, occupancy tracker and drop counters
`include "cong_man_settings.svh"

module cong_man_top import cong_man_pkg::*; (
    input  logic                      counter_access,
    input  logic                      reset,
    input  pkt_word_t                 pkt_in,
    input  logic                      deq_valid,
    input  queue_id_t                 deq_queue,
    input  byte_len_t                 deq_bytes,
    input  logic                      cfg_wr,
    input  logic                      cfg_rd,
    input  queue_id_t                 cfg_queue,
    input  occupancy_t                cfg_wdata,
    output logic                      cfg_rvalid,
    output occupancy_t                cfg_rdata,
    input  logic                      cnt_req,
    input  cnt_op_t                   cnt_op,
    input  queue_id_t                 cnt_queue,
    input  drop_type_t                cnt_type,
    output logic                      cnt_ready,
    output logic                      cnt_rvalid,
    output counter_t                  cnt_rdata,
    output logic                      pkt_out_valid,
    output logic                      pkt_out_last,
    output logic [`CM_DATA_WIDTH-1:0] pkt_out_data,
    output out_meta_t                 pkt_out_meta
);

    queue_id_t   occ_query;
    occupancy_t  occ_value;
    queue_id_t   thresh_query;
    occupancy_t  thresh_value;
    logic        enq_valid;
    queue_id_t   enq_queue;
    byte_len_t   enq_bytes;
    drop_event_t drop_event;

    cong_pipeline cong_pipeline_i (
        .counter_access (counter_access),
        .reset          (reset),
        .pkt_in         (pkt_in),
        .occ_query      (occ_query),
        .occ_value      (occ_value),
        .thresh_query   (thresh_query),
        .thresh_value   (thresh_value),
        .enq_valid      (enq_valid),
        .enq_queue      (enq_queue),
        .enq_bytes      (enq_bytes),
        .drop_event     (drop_event),
        .pkt_out_valid  (pkt_out_valid),
        .pkt_out_last   (pkt_out_last),
        .pkt_out_data   (pkt_out_data),
        .pkt_out_meta   (pkt_out_meta)
    );

    drop_threshold_table drop_threshold_table_i (
        .counter_access (counter_access),
        .reset          (reset),
        .cfg_wr         (cfg_wr),
        .cfg_rd         (cfg_rd),
        .cfg_queue      (cfg_queue),
        .cfg_wdata      (cfg_wdata),
        .cfg_rvalid     (cfg_rvalid),
        .cfg_rdata      (cfg_rdata),
        .thresh_query   (thresh_query),
        .thresh_value   (thresh_value)
    );

    queue_occupancy_tracker queue_occupancy_tracker_i (
        .counter_access (counter_access),
        .reset          (reset),
        .enq_valid      (enq_valid),
        .enq_queue      (enq_queue),
        .enq_bytes      (enq_bytes),
        .deq_valid      (deq_valid),
        .deq_queue      (deq_queue),
        .deq_bytes      (deq_bytes),
        .occ_query      (occ_query),
        .occ_value      (occ_value)
    );

    drop_counter_bank drop_counter_bank_i (
        .counter_access (counter_access),
        .reset          (reset),
        .drop_event     (drop_event),
        .cnt_req        (cnt_req),
        .cnt_op         (cnt_op),
        .cnt_queue      (cnt_queue),
        .cnt_type       (cnt_type),
        .cnt_ready      (cnt_ready),
        .cnt_rvalid     (cnt_rvalid),
        .cnt_rdata      (cnt_rdata)
    );

endmodule

//--- design/cong_pipeline.sv
// Congestion manager packet pipeline
// Three stages: queue mapping, drop decision on start of packet, output gating
`include "cong_man_settings.svh"

module cong_pipeline import cong_man_pkg::*; (
    input  logic                      counter_access,
    input  logic                      reset,
    input  pkt_word_t                 pkt_in,
    output queue_id_t                 occ_query,
    input  occupancy_t                occ_value,
    output queue_id_t                 thresh_query,
    input  occupancy_t                thresh_value,
    output logic                      enq_valid,
    output queue_id_t                 enq_queue,
    output byte_len_t                 enq_bytes,
    output drop_event_t               drop_event,
    output logic                      pkt_out_valid,
    output logic                      pkt_out_last,
    output logic [`CM_DATA_WIDTH-1:0] pkt_out_data,
    output out_meta_t                 pkt_out_meta
);

    // Next valid word opens a packet
    logic in_sop;

    logic                      s1_valid;
    logic                      s1_last;
    logic                      s1_sop;
    logic [`CM_DATA_WIDTH-1:0] s1_data;
    pkt_meta_t                 s1_meta;
    queue_id_t                 s1_queue;

    // Per-packet state held from the first word
    logic      pkt_drop;
    queue_id_t pkt_queue;
    byte_len_t pkt_len;

    logic [`CM_OCC_WIDTH:0] occ_sum;
    logic                   policer_hit;
    logic                   full_hit;
    logic                   sop_drop;
    logic                   word_drop;

    logic                      s2_valid;
    logic                      s2_last;
    logic                      s2_drop;
    logic [`CM_DATA_WIDTH-1:0] s2_data;
    out_meta_t                 s2_meta;

    ////////////////////////////////////////////////////////////////////////////
    // Stage 2 decision

    assign occ_query    = s1_queue;
    assign thresh_query = s1_queue;

    // One extra bit so a full queue plus a long packet cannot wrap
    assign occ_sum = {1'b0, occ_value}
                   + {{(`CM_OCC_WIDTH + 1 - `CM_BYTE_LEN_WIDTH){1'b0}}, s1_meta.byte_len};

    assign policer_hit = s1_meta.policer_mark
                      && (s1_meta.prio < prio_t'(`CM_POLICER_BYPASS_PRIO));
    assign full_hit    = occ_sum > {1'b0, thresh_value};
    assign sop_drop    = policer_hit || full_hit;
    assign word_drop   = s1_sop ? sop_drop : pkt_drop;

    // Accepted packets enter the occupancy at the end of this cycle
    assign enq_valid = s1_valid && s1_sop && !sop_drop;
    assign enq_queue = s1_queue;
    assign enq_bytes = s1_meta.byte_len;

    ////////////////////////////////////////////////////////////////////////////
    // Control registers

    always_ff @(posedge counter_access) begin
        if (reset) begin
            in_sop        <= 1'b1;
            s1_valid      <= 1'b0;
            s1_last       <= 1'b0;
            s1_sop        <= 1'b0;
            pkt_drop      <= 1'b0;
            s2_valid      <= 1'b0;
            s2_last       <= 1'b0;
            s2_drop       <= 1'b0;
            drop_event    <= '0;
            pkt_out_valid <= 1'b0;
            pkt_out_last  <= 1'b0;
        end else begin
            if (pkt_in.valid) begin
                in_sop <= pkt_in.last;
            end
            s1_valid <= pkt_in.valid;
            s1_last  <= pkt_in.valid && pkt_in.last;
            s1_sop   <= pkt_in.valid && in_sop;

            if (s1_valid && s1_sop) begin
                pkt_drop <= sop_drop;
            end
            s2_valid <= s1_valid;
            s2_last  <= s1_last;
            s2_drop  <= word_drop;

            // One event per dropped packet, policer wins over queue full
            drop_event.valid     <= s1_valid && s1_sop && sop_drop;
            drop_event.queue_id  <= s1_queue;
            drop_event.drop_type <= policer_hit ? POLICER_DROP : QUEUE_FULL_DROP;

            pkt_out_valid <= s2_valid && !s2_drop;
            pkt_out_last  <= s2_last && !s2_drop;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Payload registers

    always_ff @(posedge counter_access) begin
        s1_data  <= pkt_in.data;
        s1_meta  <= pkt_in.meta;
        s1_queue <= {pkt_in.meta.egress_port, prio_to_queue(pkt_in.meta.prio)};

        if (s1_valid && s1_sop) begin
            pkt_queue <= s1_queue;
            pkt_len   <= s1_meta.byte_len;
        end
        s2_data          <= s1_data;
        s2_meta.queue_id <= s1_sop ? s1_queue : pkt_queue;
        s2_meta.byte_len <= s1_sop ? s1_meta.byte_len : pkt_len;

        pkt_out_data <= s2_data;
        pkt_out_meta <= s2_meta;
    end

endmodule

//--- design/drop_counter_bank.sv
// Drop counters per queue and drop type
// Cleared by a sweep after reset, served by read, read-and-clear and clear-all
`include "cong_man_settings.svh"

module drop_counter_bank import cong_man_pkg::*; (
    input  logic        counter_access,
    input  logic        reset,
    input  drop_event_t drop_event,
    input  logic        cnt_req,
    input  cnt_op_t     cnt_op,
    input  queue_id_t   cnt_queue,
    input  drop_type_t  cnt_type,
    output logic        cnt_ready,
    output logic        cnt_rvalid,
    output counter_t    cnt_rdata
);

    counter_t counters [`CM_NUM_QUEUES][`CM_NUM_DROP_TYPES];

    counter_state_t state;
    queue_id_t      sweep_queue;
    drop_type_t     sweep_type;
    logic           sweep_done;
    logic           accept;

    // Counting takes the cycle, so access waits
    assign cnt_ready  = (state == ACTIVE) && !drop_event.valid;
    assign accept     = cnt_req && cnt_ready;
    assign sweep_done = (sweep_queue == queue_id_t'(`CM_NUM_QUEUES - 1))
                     && (sweep_type == drop_type_t'(`CM_NUM_DROP_TYPES - 1));

    ////////////////////////////////////////////////////////////////////////////
    // State machine and sweep index

    always_ff @(posedge counter_access) begin
        if (reset) begin
            state       <= INIT;
            sweep_queue <= '0;
            sweep_type  <= POLICER_DROP;
            cnt_rvalid  <= 1'b0;
        end else begin
            cnt_rvalid <= accept;
            case (state)
                INIT: begin
                    // Queue walks fastest, type steps on each wrap
                    sweep_queue <= sweep_queue + 1'b1;
                    if (sweep_queue == queue_id_t'(`CM_NUM_QUEUES - 1)) begin
                        sweep_type <= drop_type_t'(sweep_type + 1'b1);
                    end
                    if (sweep_done) begin
                        sweep_queue <= '0;
                        sweep_type  <= POLICER_DROP;
                        state       <= ACTIVE;
                    end
                end
                ACTIVE: begin
                    if (accept && cnt_op == CLEAR_ALL) begin
                        state <= INIT;
                    end
                end
                default: state <= INIT;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Counter storage and read data

    always_ff @(posedge counter_access) begin
        if (state == INIT) begin
            counters[sweep_queue][sweep_type] <= '0;
        end else if (drop_event.valid) begin
            counters[drop_event.queue_id][drop_event.drop_type] <=
                counters[drop_event.queue_id][drop_event.drop_type] + 1'b1;
        end else if (accept) begin
            case (cnt_op)
                READ: begin
                    cnt_rdata <= counters[cnt_queue][cnt_type];
                end
                READ_AND_CLEAR: begin
                    cnt_rdata                     <= counters[cnt_queue][cnt_type];
                    counters[cnt_queue][cnt_type] <= '0;
                end
                default: begin
                    cnt_rdata <= '0;
                end
            endcase
        end
    end

endmodule

//--- design/drop_threshold_table.sv
// Per-queue drop thresholds
// Written and read over the config strobes, looked up by the pipeline

module drop_threshold_table import cong_man_pkg::*; (
    input  logic       counter_access,
    input  logic       reset,
    input  logic       cfg_wr,
    input  logic       cfg_rd,
    input  queue_id_t  cfg_queue,
    input  occupancy_t cfg_wdata,
    output logic       cfg_rvalid,
    output occupancy_t cfg_rdata,
    input  queue_id_t  thresh_query,
    output occupancy_t thresh_value
);

    localparam int NUM_QUEUES = 2 ** $bits(queue_id_t);

    occupancy_t thresholds [NUM_QUEUES];

    // Pipeline lookup, same cycle
    assign thresh_value = thresholds[thresh_query];

    // All ones leaves every queue open until configured
    always_ff @(posedge counter_access) begin
        if (reset) begin
            thresholds <= '{default: '1};
            cfg_rvalid <= 1'b0;
        end else begin
            if (cfg_wr) begin
                thresholds[cfg_queue] <= cfg_wdata;
            end
            cfg_rvalid <= cfg_rd;
        end
    end

    always_ff @(posedge counter_access) begin
        if (cfg_rd) begin
            cfg_rdata <= thresholds[cfg_queue];
        end
    end

endmodule

//--- design/queue_occupancy_tracker.sv
// Per-queue byte occupancy
// Enqueues add the packet length, dequeues subtract with a floor at zero

module queue_occupancy_tracker import cong_man_pkg::*; (
    input  logic       counter_access,
    input  logic       reset,
    input  logic       enq_valid,
    input  queue_id_t  enq_queue,
    input  byte_len_t  enq_bytes,
    input  logic       deq_valid,
    input  queue_id_t  deq_queue,
    input  byte_len_t  deq_bytes,
    input  queue_id_t  occ_query,
    output occupancy_t occ_value
);

    localparam int NUM_QUEUES = 2 ** $bits(queue_id_t);

    occupancy_t occupancy [NUM_QUEUES];
    occupancy_t occ_next  [NUM_QUEUES];
    occupancy_t occ_added [NUM_QUEUES];

    assign occ_value = occupancy[occ_query];

    // Enqueue first, then dequeue, so both land in the same cycle
    always_comb begin
        for (int q = 0; q < NUM_QUEUES; q++) begin
            occ_added[q] = occupancy[q];
            if (enq_valid && enq_queue == queue_id_t'(q)) begin
                occ_added[q] = occupancy[q] + occupancy_t'(enq_bytes);
            end
            occ_next[q] = occ_added[q];
            if (deq_valid && deq_queue == queue_id_t'(q)) begin
                if (occ_added[q] > occupancy_t'(deq_bytes)) begin
                    occ_next[q] = occ_added[q] - occupancy_t'(deq_bytes);
                end else begin
                    occ_next[q] = '0;
                end
            end
        end
    end

    always_ff @(posedge counter_access) begin
        if (reset) begin
            occupancy <= '{default: '0};
        end else begin
            occupancy <= occ_next;
        end
    end

endmodule
